// File: logic/motor_pkg.sv
// motor channel package: widths, timing constants and quadrature step encoding
package motor_pkg;

	// ========================================
	// data widths
	// ========================================
	localparam int count_width = 32;	// signed position counter
	localparam int speed_width = 16;	// counts per sample window
	localparam int duty_width  = 8;	// pwm duty command

	typedef logic signed [count_width-1:0] count_t;
	typedef logic signed [speed_width-1:0] speed_t;
	typedef logic        [duty_width-1:0]  duty_t;	// unsigned, 0 = off

	// ========================================
	// timing
	// ========================================
	localparam int pwm_period_cycles    = 256;	// one full 8-bit sweep
	localparam int filter_depth         = 4;	// equal samples before a line flips
	localparam int sync_stages          = 2;	// metastability chain
	// short window so a few of them fit in simulation
	localparam int sample_period_cycles = 2000;

	// ========================================
	// decoded quadrature step
	// ========================================
	// step_error = both lines moved together, direction unknown
	typedef enum logic [1:0]
	{
		step_none  = 2'b00,
		step_up    = 2'b01,
		step_down  = 2'b10,
		step_error = 2'b11
	} step_t;

endpackage

// File: logic/encoder_if.sv
// encoder bus: filtered A/B lines and position count shared by the channel blocks
`timescale 1ns/100ps

interface encoder_if;

	logic             a_clean;	// deglitched A
	logic             b_clean;	// deglitched B
	motor_pkg::count_t position;	// signed running count
	logic             position_step;	// one-cycle strobe per counted step

	// filter owns the clean lines
	modport filter_mp
	(
		output a_clean,
		output b_clean
	);

	// decoder turns A/B edges into counts
	modport decoder_mp
	(
		input  a_clean,
		input  b_clean,
		output position,
		output position_step
	);

	modport meter_mp
	(
		input  position	// speed only needs the count
	);

endinterface

// File: logic/input_filter.sv
// input filter: synchronizes and deglitches the A/B encoder lines
`timescale 1ns/100ps

module input_filter
(
	input  logic       fpga_clk_50,
	input  logic       hps_fpga_reset_n,
	input  logic       enc_a,
	input  logic       enc_b,
	encoder_if.filter_mp enc
);

	// stability counter, counts up to filter_depth-1
	typedef logic [$clog2(motor_pkg::filter_depth)-1:0] stab_t;

	logic [1:0]                              raw;	// [1] = A, [0] = B
	logic [1:0][motor_pkg::sync_stages-1:0] sync_q;	// per-line sync chain
	stab_t [1:0]                             stab_cnt;
	logic [1:0]                              clean_q;

	assign raw = {enc_a, enc_b};

	// ========================================
	// sync chain + stability counter per line
	// ========================================
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			sync_q   <= '0;
			stab_cnt <= '0;
			clean_q  <= '0;	// lines idle low
		end
		else
		begin
			for (int i = 0; i < 2; i++)
			begin
				sync_q[i] <= {sync_q[i][motor_pkg::sync_stages-2:0], raw[i]};	// shift in
				if (sync_q[i][motor_pkg::sync_stages-1] != clean_q[i])
				begin
					// differs from filtered level, count agreeing samples
					if (stab_cnt[i] == stab_t'(motor_pkg::filter_depth - 1))
					begin
						clean_q[i]  <= sync_q[i][motor_pkg::sync_stages-1];	// accept
						stab_cnt[i] <= '0;
					end
					else
						stab_cnt[i] <= stab_cnt[i] + 1'b1;
				end
				else
					stab_cnt[i] <= '0;	// glitch gone, start over
			end
		end
	end

	assign enc.a_clean = clean_q[1];
	assign enc.b_clean = clean_q[0];

endmodule

// File: logic/quad_decoder.sv
// quadrature decoder: turns filtered A/B transitions into a signed position count
`timescale 1ns/100ps

module quad_decoder
(
	input  logic          fpga_clk_50,
	input  logic          hps_fpga_reset_n,
	encoder_if.decoder_mp enc,
	output logic          enc_error	// sticky until reset
);

	logic [1:0]       ab_prev;	// {a, b} seen last cycle
	logic [1:0]       ab_cur;
	motor_pkg::step_t step;

	assign ab_cur = {enc.a_clean, enc.b_clean};

	// ========================================
	// transition table
	// ========================================
	// forward (A leads B): 00 -> 10 -> 11 -> 01 -> 00
	// backward is the same ring walked the other way
	always_comb
	begin
		case ({ab_prev, ab_cur})
			4'b00_10, 4'b10_11, 4'b11_01, 4'b01_00: step = motor_pkg::step_up;
			4'b00_01, 4'b01_11, 4'b11_10, 4'b10_00: step = motor_pkg::step_down;
			4'b00_11, 4'b11_00, 4'b01_10, 4'b10_01: step = motor_pkg::step_error;	// both flipped
			default:                                step = motor_pkg::step_none;	// no change
		endcase
	end

	// position update one cycle after the clean lines move
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			ab_prev           <= 2'b00;
			enc.position      <= '0;
			enc.position_step <= 1'b0;
			enc_error         <= 1'b0;
		end
		else
		begin
			ab_prev <= ab_cur;
			case (step)
				motor_pkg::step_up:
				begin
					enc.position      <= enc.position + motor_pkg::count_t'(1);
					enc.position_step <= 1'b1;
				end
				motor_pkg::step_down:
				begin
					enc.position      <= enc.position - motor_pkg::count_t'(1);
					enc.position_step <= 1'b1;
				end
				motor_pkg::step_error:
				begin
					enc.position_step <= 1'b0;	// count held, direction lost
					enc_error         <= 1'b1;
				end
				default:
					enc.position_step <= 1'b0;
			endcase
		end
	end

	// count moves only on its strobe, after exactly one clean line changed
	a_pos_needs_step: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
		$changed(enc.position) |->
			enc.position_step && ($countones($past(ab_cur) ^ $past(ab_prev)) == 1))
		else $error("position changed without a single-line step");

endmodule

// File: logic/speed_meter.sv
// speed meter: reports position change over each fixed sample window
`timescale 1ns/100ps

module speed_meter
(
	input  logic              fpga_clk_50,
	input  logic              hps_fpga_reset_n,
	encoder_if.meter_mp       enc,
	output motor_pkg::speed_t speed,	// held between strobes
	output logic              speed_valid	// one cycle per window
);

	typedef logic [$clog2(motor_pkg::sample_period_cycles)-1:0] win_t;

	win_t              win_cnt;	// cycles into current window
	motor_pkg::count_t start_q;	// position at last window end
	motor_pkg::count_t diff;
	motor_pkg::speed_t speed_sat;

	// ========================================
	// difference + saturation
	// ========================================
	// fits in speed_t when the top bits are all sign copies
	always_comb
	begin
		diff = enc.position - start_q;	// wraps cleanly in 32 bits
		if ((&diff[motor_pkg::count_width-1:motor_pkg::speed_width-1]) ||
			!(|diff[motor_pkg::count_width-1:motor_pkg::speed_width-1]))
			speed_sat = motor_pkg::speed_t'(diff[motor_pkg::speed_width-1:0]);
		else if (diff[motor_pkg::count_width-1])
			speed_sat = {1'b1, {(motor_pkg::speed_width-1){1'b0}}};	// most negative
		else
			speed_sat = {1'b0, {(motor_pkg::speed_width-1){1'b1}}};	// most positive
	end

	// ========================================
	// window timer
	// ========================================
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			win_cnt     <= '0;
			start_q     <= '0;	// first window starts from zero
			speed       <= '0;
			speed_valid <= 1'b0;
		end
		else
		begin
			speed_valid <= 1'b0;
			if (win_cnt == win_t'(motor_pkg::sample_period_cycles - 1))
			begin
				win_cnt     <= '0;
				start_q     <= enc.position;	// next window's baseline
				speed       <= speed_sat;
				speed_valid <= 1'b1;
			end
			else
				win_cnt <= win_cnt + 1'b1;
		end
	end

	// strobe is a single pulse per window
	a_valid_single: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
		speed_valid |=> !speed_valid)
		else $error("speed_valid high on consecutive cycles");

endmodule

// File: logic/pwm_generator.sv
// pwm generator: free-running period counter with duty reloaded at period start
`timescale 1ns/100ps

module pwm_generator
(
	input  logic             fpga_clk_50,
	input  logic             hps_fpga_reset_n,
	input  motor_pkg::duty_t duty,	// sampled only at period start
	output logic             pwm_out
);

	motor_pkg::duty_t cnt;	// position inside the period
	motor_pkg::duty_t duty_q;	// duty of the running period
	motor_pkg::duty_t cur_duty;

	// new command takes effect on the first cycle of the period
	assign cur_duty = (cnt == '0) ? duty : duty_q;

	// ========================================
	// period counter + compare
	// ========================================
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			cnt     <= '0;
			duty_q  <= '0;
			pwm_out <= 1'b0;	// motor off
		end
		else
		begin
			if (cnt == motor_pkg::duty_t'(motor_pkg::pwm_period_cycles - 1))
				cnt <= '0;	// wrap
			else
				cnt <= cnt + 1'b1;

			if (cnt == '0)
				duty_q <= duty;	// latch

			pwm_out <= (cnt < cur_duty);	// high for the first duty cycles
		end
	end

	// zero duty keeps the drive low for the whole period, including the lagged edge
	a_zero_duty_low: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
		(duty_q == '0) |-> !pwm_out)
		else $error("pwm_out high with zero duty latched");

endmodule

// File: logic/motor_ctrl_top.sv
// motor channel top: encoder filter, decoder, speed meter and pwm drive
`timescale 1ns/100ps

module motor_ctrl_top
(
	input  logic                              fpga_clk_50,
	input  logic                              hps_fpga_reset_n,
	input  logic                              enc_a,	// raw encoder A
	input  logic                              enc_b,	// raw encoder B
	input  logic [motor_pkg::duty_width-1:0]  duty,
	output logic [motor_pkg::count_width-1:0] count,
	output logic [motor_pkg::speed_width-1:0] speed,	// counts per window
	output logic                              speed_valid,
	output logic                              pwm_out,
	output logic                              enc_error
);

	// ========================================
	// encoder path
	// ========================================
	encoder_if enc_bus ();

	// sync + deglitch, sync_stages + filter_depth cycles
	input_filter input_filter_i
	(
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.enc_a            (enc_a),
		.enc_b            (enc_b),
		.enc              (enc_bus.filter_mp)
	);

	quad_decoder quad_decoder_i
	(
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.enc              (enc_bus.decoder_mp),
		.enc_error        (enc_error)
	);

	speed_meter speed_meter_i
	(
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.enc              (enc_bus.meter_mp),
		.speed            (speed),
		.speed_valid      (speed_valid)
	);

	assign count = enc_bus.position;	// raw count straight out

	// ========================================
	// drive
	// ========================================
	pwm_generator pwm_generator_i
	(
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.duty             (duty),
		.pwm_out          (pwm_out)
	);

endmodule

// File: test/tb_motor_ctrl.sv
// motor channel testbench: random encoder and duty stimulus checked against a position model
`timescale 1ns/100ps

module tb_motor_ctrl;

	localparam int clk_period    = 40;
	localparam int step_hold     = 16;	// cycles per A/B level, above filter latency
	localparam int pos_steps     = 40;
	localparam int glitch_count  = 24;
	localparam int speed_windows = 3;
	localparam int duty_tests    = 6;
	localparam int speed_steps   = speed_windows * motor_pkg::sample_period_cycles / step_hold;
	// rough length of the whole run, in cycles
	localparam int total_cycles  = 16 + (pos_steps + 1) * step_hold
		+ glitch_count * (motor_pkg::filter_depth + step_hold) + step_hold
		+ (speed_windows + 4) * motor_pkg::sample_period_cycles
		+ duty_tests * 3 * motor_pkg::pwm_period_cycles + 2 * step_hold;

	logic                    fpga_clk_50 = 1'b0;
	logic                    hps_fpga_reset_n;
	logic                    enc_a;
	logic                    enc_b;
	motor_pkg::duty_t        duty;
	logic [31:0]             count;
	logic [15:0]             speed;
	logic                    speed_valid;
	logic                    pwm_out;
	logic                    enc_error;

	int unsigned lcg_state = 11;	// fixed seed
	int          phase;	// index into the gray ring
	int          model_pos;	// ideal position
	int          count_seen;	// last count that strayed from the model
	int          errors;
	int          tests_failed;
	int          tests_run;
	int          errors_before;
	// speed monitor state
	int          speed_sum;
	int          pulses_seen;
	int          cycle_cnt;
	int          last_pulse;

	motor_ctrl_top dut_i
	(
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.enc_a            (enc_a),
		.enc_b            (enc_b),
		.duty             (duty),
		.count            (count),
		.speed            (speed),
		.speed_valid      (speed_valid),
		.pwm_out          (pwm_out),
		.enc_error        (enc_error)
	);

	always #(clk_period / 2) fpga_clk_50 = ~fpga_clk_50;

	// ========================================
	// helpers
	// ========================================
	function automatic int rand_below(input int limit);
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;	// classic lcg constants
		return int'(lcg_state[30:16]) % limit;	// upper bits are the better ones
	endfunction

	// forward ring, A leads B
	function automatic logic [1:0] gray_ab(input int p);
		case (p)
			0:       return 2'b00;
			1:       return 2'b10;
			2:       return 2'b11;
			default: return 2'b01;
		endcase
	endfunction

	task automatic check_value(input string name, input int expected, input int actual);
		assert (expected == actual)
		else
		begin
			$display("error %s expected %0d actual %0d", name, expected, actual);
			errors++;
		end
	endtask

	task automatic drive_step(input bit forward);
		phase     = forward ? (phase + 1) % 4 : (phase + 3) % 4;
		model_pos = forward ? model_pos + 1 : model_pos - 1;
		{enc_a, enc_b} = gray_ab(phase);
		repeat (step_hold) @(negedge fpga_clk_50);
	endtask

	// waits some cycles, keeping any count that left the model
	task automatic watch_count(input int cycles);
		repeat (cycles)
		begin
			@(negedge fpga_clk_50);
			if (int'($signed(count)) != model_pos)
				count_seen = int'($signed(count));
		end
	endtask

	// returns at the falling edge where the strobe is seen
	task automatic wait_speed_pulse();
		int  n;
		bit  seen;
		n    = 0;
		seen = 1'b0;
		while (!seen && n < motor_pkg::sample_period_cycles + 4)
		begin
			@(negedge fpga_clk_50);
			n++;
			seen = speed_valid;
		end
		assert (seen)
		else
		begin
			$display("speed_valid did not pulse within one sample window");
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		tests_run++;
		if (errors == errors_before)
			$display("test %s ok", name);
		else
		begin
			$display("test %s failed with %0d errors", name, errors - errors_before);
			tests_failed++;
		end
		errors_before = errors;
	endtask

	// ========================================
	// speed monitor, sums every window result
	// ========================================
	always @(negedge fpga_clk_50)
	begin
		if (hps_fpga_reset_n)
		begin
			cycle_cnt++;
			if (speed_valid)
			begin
				if (pulses_seen > 0)
					assert (cycle_cnt - last_pulse == motor_pkg::sample_period_cycles)
					else
					begin
						$display("error speed_gap expected %0d actual %0d",
							motor_pkg::sample_period_cycles, cycle_cnt - last_pulse);
						errors++;
					end
				last_pulse = cycle_cnt;
				pulses_seen++;
				speed_sum += int'(motor_pkg::speed_t'(speed));	// sign extends
			end
		end
	end

	// watchdog
	initial
	begin
		#(2 * total_cycles * clk_period);
		$display("watchdog timeout, simulation did not reach the end of the tests");
		$display("Finished with errors");
		$finish;
	end

	// ========================================
	// test sequence
	// ========================================
	initial
	begin
		motor_pkg::duty_t duty_cmd;
		int               held;
		int               w;
		hps_fpga_reset_n = 1'b0;
		enc_a = 1'b0;
		enc_b = 1'b0;
		duty  = '0;
		phase         = 0;
		model_pos     = 0;
		count_seen    = 0;
		errors        = 0;
		tests_failed  = 0;
		tests_run     = 0;
		errors_before = 0;
		speed_sum     = 0;
		pulses_seen   = 0;
		cycle_cnt     = 0;
		last_pulse    = 0;
		repeat (5) @(negedge fpga_clk_50);
		hps_fpga_reset_n = 1'b1;
		@(negedge fpga_clk_50);

		// 1: everything idle out of reset
		check_value("reset count", 0, int'($signed(count)));
		check_value("reset speed", 0, int'(motor_pkg::speed_t'(speed)));
		check_value("reset speed_valid", 0, int'(speed_valid));
		check_value("reset pwm_out", 0, int'(pwm_out));
		check_value("reset enc_error", 0, int'(enc_error));
		report_test("reset");

		// 2: random walk, even odds each way
		repeat (pos_steps) drive_step(rand_below(2) == 1);
		repeat (step_hold) @(negedge fpga_clk_50);
		check_value("position count", model_pos, int'($signed(count)));
		report_test("position");

		// 3: short pulses die in the filter, count watched every cycle
		repeat (glitch_count)
		begin
			w = 1 + rand_below(motor_pkg::filter_depth - 1);
			count_seen = model_pos;
			if (rand_below(2) == 1)
			begin
				enc_a = ~enc_a;
				watch_count(w);
				enc_a = ~enc_a;
			end
			else
			begin
				enc_b = ~enc_b;
				watch_count(w);
				enc_b = ~enc_b;
			end
			watch_count(step_hold);
			check_value("glitch count", model_pos, count_seen);
		end
		report_test("glitch");

		// 4: mostly forward motion, then two quiet windows
		repeat (speed_steps) drive_step(rand_below(10) < 7);
		repeat (step_hold) @(negedge fpga_clk_50);
		wait_speed_pulse();	// closes the window with the last motion
		wait_speed_pulse();
		wait_speed_pulse();
		@(negedge fpga_clk_50);	// monitor has taken the last strobe
		check_value("speed sum", model_pos, speed_sum);
		check_value("speed count", model_pos, int'($signed(count)));
		assert (pulses_seen > speed_windows)
		else
		begin
			$display("too few speed_valid pulses seen: %0d", pulses_seen);
			errors++;
		end
		report_test("speed");

		// 5: duty sweep, both extremes first
		for (int t = 0; t < duty_tests; t++)
		begin
			if (t == 0)
				duty_cmd = '0;
			else if (t == 1)
				duty_cmd = motor_pkg::duty_t'(255);
			else
				duty_cmd = motor_pkg::duty_t'(rand_below(256));
			duty = duty_cmd;
			// first period may still run the old duty
			repeat (motor_pkg::pwm_period_cycles + 2) @(negedge fpga_clk_50);
			held = 0;
			repeat (motor_pkg::pwm_period_cycles)
			begin
				@(negedge fpga_clk_50);
				if (pwm_out)
					held++;
			end
			check_value("pwm high cycles", int'(duty_cmd), held);
			repeat (motor_pkg::pwm_period_cycles - 2) @(negedge fpga_clk_50);
		end
		report_test("pwm");

		// 6: both lines flip together
		{enc_a, enc_b} = ~{enc_a, enc_b};
		repeat (step_hold) @(negedge fpga_clk_50);
		check_value("illegal enc_error", 1, int'(enc_error));
		check_value("illegal count", model_pos, int'($signed(count)));
		report_test("illegal");

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: sources.f
logic/motor_pkg.sv
logic/encoder_if.sv
logic/input_filter.sv
logic/quad_decoder.sv
logic/speed_meter.sv
logic/pwm_generator.sv
logic/motor_ctrl_top.sv
test/tb_motor_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# builds the motor channel testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_motor_ctrl \
	-Mdir obj_dir -o tb_motor_ctrl

sim_out=$(./obj_dir/tb_motor_ctrl)
echo "$sim_out"

if echo "$sim_out" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1
